//--- fftPkg.sv
package fftPkg;

    // transform size and stage count
    localparam int fftN    = 32;
    localparam int fftLogN = 5;

    // one real or imaginary part
    localparam int dataW = 16;

    // twiddles are Q1.14
    localparam int twW    = 16;
    localparam int twFrac = 14;

    typedef logic [fftLogN-1:0] addrT;

    typedef struct packed {
        logic signed [dataW-1:0] re;
        logic signed [dataW-1:0] im;
    } cplxT;

    // load doubles as idle
    typedef enum logic [1:0] {
        stLoad,
        stCompute,
        stDrain,
        stUnload
    } ctrlStateT;

endpackage

//--- fftMemIf.sv
`timescale 1ns/1ns

interface fftMemIf;
    import fftPkg::*;

    // load path into bank 0
    logic loadEn;
    addrT loadAddr;

    // butterfly and unload addressing
    addrT rdAddrG;
    addrT rdAddrH;
    addrT wrAddrG;
    addrT wrAddrH;
    logic wrEn;
    logic rdBank;

    // read data and butterfly results
    cplxT rdG;
    cplxT rdH;
    cplxT resX;
    cplxT resY;

    modport ctrl (
        output loadEn, loadAddr, rdAddrG, rdAddrH, wrAddrG, wrAddrH, wrEn, rdBank
    );

    modport mem (
        input  loadEn, loadAddr, rdAddrG, rdAddrH, wrAddrG, wrAddrH, wrEn, rdBank,
        input  resX, resY,
        output rdG, rdH
    );

    modport bfly (
        input  rdG, rdH,
        output resX, resY
    );

endinterface

//--- fftBankRam.sv
`timescale 1ns/1ns

module fftBankRam (
    input  logic         clock,
    input  logic         aEn_i,
    input  logic         bEn_i,
    input  fftPkg::addrT aAddr_i,
    input  fftPkg::addrT bAddr_i,
    input  fftPkg::cplxT aData_i,
    input  fftPkg::cplxT bData_i,
    output fftPkg::cplxT aData_o,
    output fftPkg::cplxT bData_o
);
    import fftPkg::*;

    cplxT mem [fftN];

    // both ports may write in the same cycle, addresses differ
    always_ff @(posedge clock) begin
        if (aEn_i) begin
            mem[aAddr_i] <= aData_i;
        end
        if (bEn_i) begin
            mem[bAddr_i] <= bData_i;
        end
    end

    // read returns the old word
    always_ff @(posedge clock) begin
        aData_o <= mem[aAddr_i];
        bData_o <= mem[bAddr_i];
    end

endmodule

//--- fftDataMem.sv
`timescale 1ns/1ns

module fftDataMem (
    input  logic         clock,
    input  logic         rstN_i,
    fftMemIf.mem         memIf,
    input  fftPkg::cplxT loadData_i
);
    import fftPkg::*;

    cplxT loadDataQ;
    logic rdBankQ;

    logic aEn [2];
    logic bEn [2];
    addrT aAddr [2];
    addrT bAddr [2];
    cplxT aDataIn [2];
    cplxT bDataIn [2];
    cplxT aDataOut [2];
    cplxT bDataOut [2];

    // sample is written one cycle after it is accepted
    always_ff @(posedge clock) begin
        loadDataQ <= loadData_i;
    end

    // output select follows the RAM read latency
    always_ff @(posedge clock) begin
        if (!rstN_i) begin
            rdBankQ <= 1'b0;
        end else begin
            rdBankQ <= memIf.rdBank;
        end
    end

    for (genvar gb = 0; gb < 2; gb++) begin : genBank
        logic wrSide;
        logic loadSel;

        // the bank not being read takes the butterfly results
        assign wrSide  = (memIf.rdBank != gb[0]);
        assign loadSel = (gb == 0) && memIf.loadEn;

        always_comb begin
            aEn[gb]     = (wrSide && memIf.wrEn) || loadSel;
            bEn[gb]     = wrSide && memIf.wrEn;
            bAddr[gb]   = wrSide ? memIf.wrAddrH : memIf.rdAddrH;
            bDataIn[gb] = memIf.resY;
            if (loadSel) begin
                aAddr[gb]   = memIf.loadAddr;
                aDataIn[gb] = loadDataQ;
            end else begin
                aAddr[gb]   = wrSide ? memIf.wrAddrG : memIf.rdAddrG;
                aDataIn[gb] = memIf.resX;
            end
        end

        fftBankRam uBank (
            .clock   (clock),
            .aEn_i   (aEn[gb]),
            .bEn_i   (bEn[gb]),
            .aAddr_i (aAddr[gb]),
            .bAddr_i (bAddr[gb]),
            .aData_i (aDataIn[gb]),
            .bData_i (bDataIn[gb]),
            .aData_o (aDataOut[gb]),
            .bData_o (bDataOut[gb])
        );
    end

    // G from port A, H from port B
    assign memIf.rdG = aDataOut[rdBankQ];
    assign memIf.rdH = bDataOut[rdBankQ];

endmodule

//--- fftTwiddleRom.sv
`timescale 1ns/1ns

module fftTwiddleRom (
    input  logic                        clock,
    input  logic [fftPkg::fftLogN-2:0] twAddr_i,
    output fftPkg::cplxT                tw_o
);
    import fftPkg::*;

    cplxT twVal;

    // W32^k = cos(2 pi k/32) - j sin(2 pi k/32), Q1.14
    always_comb begin
        case (twAddr_i)
            4'd0:    twVal = '{16'sd16384, 16'sd0};
            4'd1:    twVal = '{16'sd16069, -16'sd3196};
            4'd2:    twVal = '{16'sd15137, -16'sd6270};
            4'd3:    twVal = '{16'sd13623, -16'sd9102};
            4'd4:    twVal = '{16'sd11585, -16'sd11585};
            4'd5:    twVal = '{16'sd9102, -16'sd13623};
            4'd6:    twVal = '{16'sd6270, -16'sd15137};
            4'd7:    twVal = '{16'sd3196, -16'sd16069};
            4'd8:    twVal = '{16'sd0, -16'sd16384};
            4'd9:    twVal = '{-16'sd3196, -16'sd16069};
            4'd10:   twVal = '{-16'sd6270, -16'sd15137};
            4'd11:   twVal = '{-16'sd9102, -16'sd13623};
            4'd12:   twVal = '{-16'sd11585, -16'sd11585};
            4'd13:   twVal = '{-16'sd13623, -16'sd9102};
            4'd14:   twVal = '{-16'sd15137, -16'sd6270};
            4'd15:   twVal = '{-16'sd16069, -16'sd3196};
            default: twVal = '{16'sd16384, 16'sd0};
        endcase
    end

    // registered so it lines up with the data RAM output
    always_ff @(posedge clock) begin
        tw_o <= twVal;
    end

endmodule

//--- fftButterfly.sv
`timescale 1ns/1ns

module fftButterfly (
    input  logic         clock,
    input  logic         rstN_i,
    fftMemIf.bfly        memIf,
    input  fftPkg::cplxT tw_i,
    input  logic         issueValid_i,
    output logic         resValid_o
);
    import fftPkg::*;

    logic signed [dataW+twW:0] prRe;
    logic signed [dataW+twW:0] prIm;
    logic signed [dataW+1:0]   whRe;
    logic signed [dataW+1:0]   whIm;
    logic signed [dataW+2:0]   sXRe, sXIm, sYRe, sYIm;
    cplxT gQ;
    logic [2:0] validQ;

    // complex product H * W
    assign prRe = memIf.rdH.re * tw_i.re - memIf.rdH.im * tw_i.im;
    assign prIm = memIf.rdH.re * tw_i.im + memIf.rdH.im * tw_i.re;

    // first pipe stage, product shifted right by 14
    always_ff @(posedge clock) begin
        whRe <= prRe[twFrac+dataW+1:twFrac];
        whIm <= prIm[twFrac+dataW+1:twFrac];
        gQ   <= memIf.rdG;
    end

    assign sXRe = gQ.re + whRe;
    assign sXIm = gQ.im + whIm;
    assign sYRe = gQ.re - whRe;
    assign sYIm = gQ.im - whIm;

    // second pipe stage, halve each output
    always_ff @(posedge clock) begin
        memIf.resX.re <= sXRe[dataW:1];
        memIf.resX.im <= sXIm[dataW:1];
        memIf.resY.re <= sYRe[dataW:1];
        memIf.resY.im <= sYIm[dataW:1];
    end

    // bit 0 marks data at the RAM output, bit 2 the results
    always_ff @(posedge clock) begin
        if (!rstN_i) begin
            validQ <= '0;
        end else begin
            validQ <= {validQ[1:0], issueValid_i};
        end
    end

    assign resValid_o = validQ[2];

endmodule

//--- fftControl.sv
`timescale 1ns/1ns

module fftControl (
    input  logic                        clock,
    input  logic                        rstN_i,
    fftMemIf.ctrl                       memIf,
    input  logic                        inValid_i,
    output logic                        inReady_o,
    output logic                        outValid_o,
    input  logic                        outReady_i,
    output logic [fftPkg::fftLogN-2:0] twAddr_o,
    output logic                        issueValid_o,
    input  logic                        resValid_i
);
    import fftPkg::*;

    ctrlStateT state;
    addrT loadCnt;
    addrT loadRev;
    addrT loadAddrQ;
    logic loadEnQ;
    logic loadLastQ;
    logic accept;
    logic [2:0] stage;
    logic [fftLogN-2:0] bCnt;
    logic [1:0] dCnt;
    addrT lowMask;
    addrT gAddr;
    addrT hAddr;
    addrT gPipe [3];
    addrT hPipe [3];
    logic [fftLogN:0] uCnt;
    addrT uShown;
    logic uIssue;
    logic outValidQ;

    assign inReady_o = (state == stLoad) && !loadLastQ;
    assign accept    = inValid_i && inReady_o;
    assign loadRev   = {<<{loadCnt}};

    // butterfly b of stage s: G has a zero inserted at bit s, H = G + 2^s
    assign lowMask  = (addrT'(1) << stage) - addrT'(1);
    assign gAddr    = ({1'b0, bCnt} & lowMask) | (({1'b0, bCnt} & ~lowMask) << 1);
    assign hAddr    = gAddr | (addrT'(1) << stage);
    assign twAddr_o = (bCnt & lowMask[fftLogN-2:0]) << (3'(fftLogN - 1) - stage);

    assign issueValid_o = (state == stCompute);

    // next bin may be read when the output slot frees up
    assign uIssue = (state == stUnload) && !uCnt[fftLogN] && (!outValidQ || outReady_i);
    assign outValid_o = outValidQ;

    assign memIf.loadEn   = loadEnQ;
    assign memIf.loadAddr = loadAddrQ;
    assign memIf.rdAddrG  = (state != stUnload) ? gAddr :
                            (uIssue ? uCnt[fftLogN-1:0] : uShown);
    assign memIf.rdAddrH  = hAddr;
    assign memIf.wrAddrG  = gPipe[2];
    assign memIf.wrAddrH  = hPipe[2];
    assign memIf.wrEn     = resValid_i;
    // result of the last stage sits in bank 1
    assign memIf.rdBank   = (state == stUnload) ? 1'b1 : stage[0];

    always_ff @(posedge clock) begin
        if (!rstN_i) begin
            state     <= stLoad;
            loadCnt   <= '0;
            loadEnQ   <= 1'b0;
            loadLastQ <= 1'b0;
            stage     <= '0;
            bCnt      <= '0;
            dCnt      <= '0;
            uCnt      <= '0;
            outValidQ <= 1'b0;
        end else begin
            loadEnQ   <= accept;
            loadLastQ <= accept && (loadCnt == addrT'(fftN - 1));
            case (state)
                stLoad: begin
                    if (accept) begin
                        loadCnt <= loadCnt + 1'b1;
                    end
                    // start once the last sample is in the RAM
                    if (loadLastQ) begin
                        state <= stCompute;
                        stage <= '0;
                        bCnt  <= '0;
                    end
                end
                stCompute: begin
                    bCnt <= bCnt + 1'b1;
                    if (bCnt == '1) begin
                        state <= stDrain;
                        dCnt  <= 2'd2;
                    end
                end
                stDrain: begin
                    dCnt <= dCnt - 1'b1;
                    if (dCnt == '0) begin
                        if (stage == 3'(fftLogN - 1)) begin
                            state <= stUnload;
                            uCnt  <= '0;
                        end else begin
                            state <= stCompute;
                            stage <= stage + 1'b1;
                        end
                    end
                end
                stUnload: begin
                    if (uIssue) begin
                        uCnt      <= uCnt + 1'b1;
                        outValidQ <= 1'b1;
                    end else if (outValidQ && outReady_i) begin
                        // last bin taken
                        outValidQ <= 1'b0;
                        state     <= stLoad;
                        stage     <= '0;
                    end
                end
                default: state <= stLoad;
            endcase
        end
    end

    // write addresses trail issue by RAM read plus butterfly latency
    always_ff @(posedge clock) begin
        loadAddrQ <= loadRev;
        gPipe[0]  <= gAddr;
        gPipe[1]  <= gPipe[0];
        gPipe[2]  <= gPipe[1];
        hPipe[0]  <= hAddr;
        hPipe[1]  <= hPipe[0];
        hPipe[2]  <= hPipe[1];
        if (uIssue) begin
            uShown <= uCnt[fftLogN-1:0];
        end
    end

endmodule

//--- fftTop.sv
`timescale 1ns/1ns

module fftTop (
    input  logic                      clock,
    input  logic                      rstN_i,
    input  logic                      inValid_i,
    output logic                      inReady_o,
    input  logic [fftPkg::dataW-1:0] inRe_i,
    input  logic [fftPkg::dataW-1:0] inIm_i,
    output logic                      outValid_o,
    input  logic                      outReady_i,
    output logic [fftPkg::dataW-1:0] outRe_o,
    output logic [fftPkg::dataW-1:0] outIm_o
);
    import fftPkg::*;

    logic [fftLogN-2:0] twAddr;
    cplxT tw;
    cplxT loadData;
    logic issueValid;
    logic resValid;

    fftMemIf memIf ();

    assign loadData = '{re: inRe_i, im: inIm_i};

    fftControl uControl (
        .clock        (clock),
        .rstN_i       (rstN_i),
        .memIf        (memIf.ctrl),
        .inValid_i    (inValid_i),
        .inReady_o    (inReady_o),
        .outValid_o   (outValid_o),
        .outReady_i   (outReady_i),
        .twAddr_o     (twAddr),
        .issueValid_o (issueValid),
        .resValid_i   (resValid)
    );

    fftDataMem uDataMem (
        .clock      (clock),
        .rstN_i     (rstN_i),
        .memIf      (memIf.mem),
        .loadData_i (loadData)
    );

    fftTwiddleRom uTwiddleRom (
        .clock    (clock),
        .twAddr_i (twAddr),
        .tw_o     (tw)
    );

    fftButterfly uButterfly (
        .clock        (clock),
        .rstN_i       (rstN_i),
        .memIf        (memIf.bfly),
        .tw_i         (tw),
        .issueValid_i (issueValid),
        .resValid_o   (resValid)
    );

    // bins come out on port A of bank 1
    assign outRe_o = memIf.rdG.re;
    assign outIm_o = memIf.rdG.im;

endmodule

//--- fftTop_assertions.sv
`timescale 1ns/1ns

module fftTop_assertions (
    input logic                     clock,
    input logic                     rstN_i,
    input logic                     inReady_i,
    input logic                     outValid_i,
    input logic                     outReady_i,
    input logic [fftPkg::dataW-1:0] outRe_i,
    input logic [fftPkg::dataW-1:0] outIm_i
);

    // a stalled bin keeps its value
    assert property (@(posedge clock) disable iff (!rstN_i)
        outValid_i && !outReady_i |=> outValid_i && $stable({outRe_i, outIm_i}))
        else $error("output bin changed while stalled");

    // no input while a bin is offered
    assert property (@(posedge clock) disable iff (!rstN_i)
        outValid_i |-> !inReady_i)
        else $error("inReady_o high while outValid_o is high");

    assert property (@(posedge clock) !rstN_i |=> !outValid_i)
        else $error("outValid_o high right after reset");

endmodule

bind fftTop fftTop_assertions uAssertions (
    .clock      (clock),
    .rstN_i     (rstN_i),
    .inReady_i  (inReady_o),
    .outValid_i (outValid_o),
    .outReady_i (outReady_i),
    .outRe_i    (outRe_o),
    .outIm_i    (outIm_o)
);

//--- tbFft.sv
`timescale 1ns/1ns

module tbFft;
    import fftPkg::*;

    localparam int waitLimit = 2000;
    localparam real twoPi = 6.283185307179586;

    logic clock;
    logic rstN_i;
    logic inValid_i;
    logic inReady_o;
    logic [dataW-1:0] inRe_i;
    logic [dataW-1:0] inIm_i;
    logic outValid_o;
    logic outReady_i;
    logic [dataW-1:0] outRe_o;
    logic [dataW-1:0] outIm_o;

    cplxT frameIn [fftN];
    cplxT frameExp [fftN];
    int inGapPct;
    int outGapPct;

    fftTop dut_i (
        .clock      (clock),
        .rstN_i     (rstN_i),
        .inValid_i  (inValid_i),
        .inReady_o  (inReady_o),
        .inRe_i     (inRe_i),
        .inIm_i     (inIm_i),
        .outValid_o (outValid_o),
        .outReady_i (outReady_i),
        .outRe_o    (outRe_o),
        .outIm_o    (outIm_o)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic stopRun(string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic compareCplx(string name, cplxT got, cplxT exp);
        if (got !== exp) begin
            stopRun($sformatf("ERR %s got re=%h im=%h, expected re=%h im=%h",
                              name, got.re, got.im, exp.re, exp.im));
        end
    endtask

    task automatic compareBit(string name, logic got, logic exp);
        if (got !== exp) begin
            stopRun($sformatf("ERR %s got %h, expected %h", name, got, exp));
        end
    endtask

    function automatic int bitRev(int idx);
        int r;
        r = 0;
        for (int b = 0; b < fftLogN; b++) begin
            r = (r << 1) | ((idx >> b) & 1);
        end
        return r;
    endfunction

    // round to nearest with halves away from zero
    function automatic int roundQ(real x);
        if (x >= 0.0) begin
            return $rtoi(x + 0.5);
        end
        return -$rtoi(0.5 - x);
    endfunction

    // radix-2 DIT on bit-reversed input with Q1.14 twiddles and halving per stage
    function automatic void buildModel();
        cplxT work [fftN];
        int span, g, h, k, wRe, wIm, pRe, pIm, gRe, gIm;
        for (int i = 0; i < fftN; i++) begin
            work[bitRev(i)] = frameIn[i];
        end
        for (int s = 0; s < fftLogN; s++) begin
            span = 1 << s;
            for (int b = 0; b < fftN / 2; b++) begin
                g = ((b >> s) << (s + 1)) | (b & (span - 1));
                h = g + span;
                k = (b & (span - 1)) << (fftLogN - 1 - s);
                wRe = roundQ(16384.0 * $cos(twoPi * k / fftN));
                wIm = -roundQ(16384.0 * $sin(twoPi * k / fftN));
                pRe = (work[h].re * wRe - work[h].im * wIm) >>> twFrac;
                pIm = (work[h].re * wIm + work[h].im * wRe) >>> twFrac;
                gRe = work[g].re;
                gIm = work[g].im;
                work[g].re = 16'((gRe + pRe) >>> 1);
                work[g].im = 16'((gIm + pIm) >>> 1);
                work[h].re = 16'((gRe - pRe) >>> 1);
                work[h].im = 16'((gIm - pIm) >>> 1);
            end
        end
        for (int i = 0; i < fftN; i++) begin
            frameExp[i] = work[i];
        end
    endfunction

    // magnitudes stay below 0x4000
    function automatic void randomFrame();
        for (int i = 0; i < fftN; i++) begin
            frameIn[i].re = 16'(int'($urandom_range(32766)) - 16383);
            frameIn[i].im = 16'(int'($urandom_range(32766)) - 16383);
        end
        buildModel();
    endfunction

    task automatic sendFrame();
        int tries;
        for (int i = 0; i < fftN; i++) begin
            tries = 0;
            do begin
                @(negedge clock);
                tries++;
                if (tries > waitLimit) begin
                    stopRun($sformatf("no inReady_o for sample %0d in time", i));
                end
                inValid_i = ($urandom_range(99) >= inGapPct);
                inRe_i    = frameIn[i].re;
                inIm_i    = frameIn[i].im;
            end while (!(inValid_i && inReady_o));
        end
    endtask

    // input must stay refused until the last bin has gone
    task automatic collectFrame();
        int tries;
        cplxT got;
        for (int k = 0; k < fftN; k++) begin
            tries = 0;
            do begin
                @(negedge clock);
                tries++;
                if (tries > waitLimit) begin
                    stopRun($sformatf("bin %0d did not arrive in time", k));
                end
                compareBit("inReady_o", inReady_o, 1'b0);
                outReady_i = ($urandom_range(99) >= outGapPct);
            end while (!(outValid_o && outReady_i));
            got.re = outRe_o;
            got.im = outIm_o;
            compareCplx($sformatf("outRe_o/outIm_o bin %0d", k), got, frameExp[k]);
        end
    endtask

    task automatic testReset();
        @(negedge clock);
        compareBit("outValid_o", outValid_o, 1'b0);
        compareBit("inReady_o", inReady_o, 1'b1);
    endtask

    task automatic testImpulse();
        for (int i = 0; i < fftN; i++) begin
            frameIn[i]  = '{re: 16'sh0000, im: 16'sh0000};
            frameExp[i] = '{re: 16'sh0100, im: 16'sh0000};
        end
        frameIn[0].re = 16'sh2000;
        sendFrame();
        collectFrame();
    endtask

    task automatic testDc();
        for (int i = 0; i < fftN; i++) begin
            frameIn[i]  = '{re: 16'sh1000, im: 16'sh0000};
            frameExp[i] = '{re: 16'sh0000, im: 16'sh0000};
        end
        frameExp[0].re = 16'sh1000;
        sendFrame();
        collectFrame();
    endtask

    task automatic testRandomFrame(int inGap, int outGap);
        inGapPct  = inGap;
        outGapPct = outGap;
        randomFrame();
        sendFrame();
        collectFrame();
    endtask

    initial begin
        void'($urandom(32'h3e35_863c));
        rstN_i     = 1'b0;
        inValid_i  = 1'b0;
        inRe_i     = '0;
        inIm_i     = '0;
        outReady_i = 1'b0;
        inGapPct   = 0;
        outGapPct  = 0;
        repeat (10) @(negedge clock);
        rstN_i = 1'b1;

        testReset();
        testImpulse();
        testDc();
        testRandomFrame(0, 0);
        // gaps on both sides
        testRandomFrame(30, 40);
        testRandomFrame(0, 0);
        testRandomFrame(0, 0);

        $display("Everything OK");
        $finish;
    end

endmodule

//--- filelist.f
fftPkg.sv
fftMemIf.sv
fftBankRam.sv
fftDataMem.sv
fftTwiddleRom.sv
fftButterfly.sv
fftControl.sv
fftTop.sv
fftTop_assertions.sv
tbFft.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tbFft -f filelist.f
	@out=$$(./obj_dir/VtbFft); echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
